// ==== conv_cfg_pkg.sv ====
// configuration package with the register map and AXI4-Lite field types of the engine
`default_nettype none

package conv_cfg_pkg;

   typedef logic [3:0]  addr_t;      // byte address in the register block
   typedef logic [31:0] data_t;
   typedef logic [3:0]  strb_t;
   typedef logic [1:0]  resp_t;
   typedef logic [15:0] line_len_t;  // image width in pixels
   typedef logic [7:0]  nfeat_t;     // output feature count

   localparam addr_t REG_CTRL     = 4'h0;
   localparam addr_t REG_LINE_LEN = 4'h4;
   localparam addr_t REG_NFEAT    = 4'h8;
   localparam addr_t REG_STATUS   = 4'hC;

   // control pulses
   localparam int CTRL_START = 0;
   localparam int CTRL_CLEAR = 1;

   // status fields, state code in bits 3:0
   localparam int STAT_BUSY    = 4;
   localparam int STAT_NOG_LSB = 8;

   localparam resp_t RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// ==== conv_data_pkg.sv ====
// data package with pixel, weight and accumulator types and the engine state codes
`default_nettype none

package conv_data_pkg;

   localparam int N_TAPS = 9;               // 3x3 filter
   localparam int PIX_W  = 8;
   localparam int WIN_W  = N_TAPS * PIX_W;  // packed window

   typedef logic signed [PIX_W-1:0] pixel_t;
   typedef logic signed [7:0]       weight_t;
   typedef logic signed [31:0]      acc_t;

   // codes are the ones reported in STATUS
   typedef enum logic [3:0] {
      FSM_IDLE              = 4'd0,
      FSM_PRELOAD           = 4'd1,
      FSM_CHANGE_FEAT       = 4'd2,
      FSM_RUN               = 4'd3,
      FSM_RELOAD_WEIGHTS    = 4'd5,
      FSM_TERMINATE_PENDING = 4'd6,
      FSM_PLWL              = 4'd9   // preload with weight load
   } fsm_state_t;

endpackage

`default_nettype wire

// ==== conv_stream_if.sv ====
// stream and control interfaces that link the stages of the convolution engine
`timescale 1ns/10ps
`default_nettype none

interface conv_stream_if #(
   parameter int DATA_W = 8
);
   logic              valid;
   logic              ready;
   logic [DATA_W-1:0] data;
   logic              last;

   modport source (output valid, output data, output last, input ready);
   modport sink   (input valid, input data, input last, output ready);
endinterface

interface conv_ctrl_if;
   logic x_enable;      // pixel acceptance allowed
   logic out_enable;    // windows may enter the MAC
   logic x_fire;
   logic x_last_fire;
   logic y_last_fire;
   logic pipe_clear;

   modport fsm      (output x_enable, output out_enable, output pipe_clear,
                     input x_fire, input x_last_fire, input y_last_fire);
   modport datapath (input x_enable, input out_enable, input pipe_clear,
                     output x_fire, output x_last_fire, output y_last_fire);
endinterface

`default_nettype wire

// ==== conv_regfile.sv ====
// AXI4-Lite register block for engine start and clear, configuration and status
`timescale 1ns/10ps
`default_nettype none

module conv_regfile (
   input  logic                      clk,
   input  logic                      rst_n,
   input  conv_cfg_pkg::addr_t       s_axi_awaddr_i,
   input  logic                      s_axi_awvalid_i,
   output logic                      s_axi_awready_o,
   input  conv_cfg_pkg::data_t       s_axi_wdata_i,
   input  conv_cfg_pkg::strb_t       s_axi_wstrb_i,
   input  logic                      s_axi_wvalid_i,
   output logic                      s_axi_wready_o,
   output conv_cfg_pkg::resp_t       s_axi_bresp_o,
   output logic                      s_axi_bvalid_o,
   input  logic                      s_axi_bready_i,
   input  conv_cfg_pkg::addr_t       s_axi_araddr_i,
   input  logic                      s_axi_arvalid_i,
   output logic                      s_axi_arready_o,
   output conv_cfg_pkg::data_t       s_axi_rdata_o,
   output conv_cfg_pkg::resp_t       s_axi_rresp_o,
   output logic                      s_axi_rvalid_o,
   input  logic                      s_axi_rready_i,
   input  conv_data_pkg::fsm_state_t state_i,
   input  conv_cfg_pkg::nfeat_t      n_og_i,
   output logic                      start_o,
   output logic                      clear_o,
   output conv_cfg_pkg::line_len_t   line_len_o,
   output conv_cfg_pkg::nfeat_t      nfeat_o
);

   logic                wr_en;
   logic                rd_en;
   conv_cfg_pkg::data_t status;

   assign wr_en          = s_axi_awready_o & s_axi_awvalid_i & s_axi_wvalid_i;
   assign rd_en          = s_axi_arready_o & s_axi_arvalid_i;
   assign s_axi_wready_o = s_axi_awready_o;   // address and data taken together
   assign s_axi_bresp_o  = conv_cfg_pkg::RESP_OKAY;
   assign s_axi_rresp_o  = conv_cfg_pkg::RESP_OKAY;

   always_comb begin
      status = '0;
      status[3:0] = state_i;
      status[conv_cfg_pkg::STAT_BUSY] = (state_i != conv_data_pkg::FSM_IDLE);
      status[conv_cfg_pkg::STAT_NOG_LSB +: 8] = n_og_i;
   end

   // write channel
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s_axi_awready_o <= 1'b0;
         s_axi_bvalid_o  <= 1'b0;
         start_o         <= 1'b0;
         clear_o         <= 1'b0;
         line_len_o      <= '0;
         nfeat_o         <= '0;
      end else begin
         s_axi_awready_o <= ~s_axi_awready_o & s_axi_awvalid_i & s_axi_wvalid_i & ~s_axi_bvalid_o;
         start_o <= 1'b0;   // pulses
         clear_o <= 1'b0;
         if (wr_en) begin
            s_axi_bvalid_o <= 1'b1;
            case (s_axi_awaddr_i)
               conv_cfg_pkg::REG_CTRL: begin
                  if (s_axi_wstrb_i[0]) begin
                     start_o <= s_axi_wdata_i[conv_cfg_pkg::CTRL_START];
                     clear_o <= s_axi_wdata_i[conv_cfg_pkg::CTRL_CLEAR];
                  end
               end
               conv_cfg_pkg::REG_LINE_LEN: begin
                  if (s_axi_wstrb_i[0]) line_len_o[7:0]  <= s_axi_wdata_i[7:0];
                  if (s_axi_wstrb_i[1]) line_len_o[15:8] <= s_axi_wdata_i[15:8];
               end
               conv_cfg_pkg::REG_NFEAT: begin
                  if (s_axi_wstrb_i[0]) nfeat_o <= s_axi_wdata_i[7:0];
               end
               default: ;   // status and holes ignore writes
            endcase
         end else if (s_axi_bready_i) begin
            s_axi_bvalid_o <= 1'b0;
         end
      end
   end

   // read channel, data one cycle after acceptance
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s_axi_arready_o <= 1'b0;
         s_axi_rvalid_o  <= 1'b0;
         s_axi_rdata_o   <= '0;
      end else begin
         s_axi_arready_o <= ~s_axi_arready_o & s_axi_arvalid_i & ~s_axi_rvalid_o;
         if (rd_en) begin
            s_axi_rvalid_o <= 1'b1;
            case (s_axi_araddr_i)
               conv_cfg_pkg::REG_LINE_LEN: s_axi_rdata_o <= {16'd0, line_len_o};
               conv_cfg_pkg::REG_NFEAT:    s_axi_rdata_o <= {24'd0, nfeat_o};
               conv_cfg_pkg::REG_STATUS:   s_axi_rdata_o <= status;
               default:                    s_axi_rdata_o <= '0;
            endcase
         end else if (s_axi_rready_i) begin
            s_axi_rvalid_o <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== conv_engine_fsm.sv ====
// engine control FSM with preload counting, weight handshake and feature counting
`timescale 1ns/10ps
`default_nettype none

module conv_engine_fsm (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      start_i,
   input  logic                      clear_i,
   input  conv_cfg_pkg::line_len_t   line_len_i,
   input  conv_cfg_pkg::nfeat_t      nfeat_i,
   input  logic                      weight_done_i,
   output logic                      weight_start_o,
   output conv_data_pkg::fsm_state_t state_o,
   output conv_cfg_pkg::nfeat_t      n_og_o,
   conv_ctrl_if.fsm                  ctrl
);

   conv_data_pkg::fsm_state_t state;
   logic [16:0]               pl_cnt;     // pixels taken while preloading
   logic [16:0]               pl_max;
   logic                      pl_done;
   logic                      preloading;
   conv_cfg_pkg::nfeat_t      nfeat_eff;
   logic                      more_feat;

   assign state_o    = state;
   assign pl_max     = {line_len_i, 1'b0} + 17'd2;   // two lines plus two pixels
   assign pl_done    = (pl_cnt >= pl_max);
   assign preloading = (state == conv_data_pkg::FSM_PLWL) ||
                       (state == conv_data_pkg::FSM_PRELOAD) ||
                       (state == conv_data_pkg::FSM_RELOAD_WEIGHTS);
   assign nfeat_eff  = (nfeat_i == '0) ? 8'd1 : nfeat_i;
   assign more_feat  = ({1'b0, n_og_o} + 9'd1) < {1'b0, nfeat_eff};

   always_comb begin
      ctrl.x_enable   = (state == conv_data_pkg::FSM_RUN) || (preloading && !pl_done);
      ctrl.out_enable = (state == conv_data_pkg::FSM_RUN) ||
                        (state == conv_data_pkg::FSM_CHANGE_FEAT) ||
                        (state == conv_data_pkg::FSM_TERMINATE_PENDING);
      ctrl.pipe_clear = clear_i || (state == conv_data_pkg::FSM_IDLE);
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pl_cnt <= '0;
      end else if (clear_i || !preloading) begin
         pl_cnt <= '0;
      end else if (ctrl.x_fire) begin
         pl_cnt <= pl_cnt + 17'd1;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state          <= conv_data_pkg::FSM_IDLE;
         weight_start_o <= 1'b0;
         n_og_o         <= '0;
      end else begin
         weight_start_o <= 1'b0;
         if (clear_i) begin
            state  <= conv_data_pkg::FSM_IDLE;
            n_og_o <= '0;
         end else begin
            case (state)
               conv_data_pkg::FSM_IDLE: begin
                  if (start_i) begin
                     state          <= conv_data_pkg::FSM_PLWL;
                     weight_start_o <= 1'b1;
                     n_og_o         <= '0;
                  end
               end
               conv_data_pkg::FSM_PLWL: begin
                  if (weight_done_i && pl_done)
                     state <= conv_data_pkg::FSM_RUN;
                  else if (weight_done_i)
                     state <= conv_data_pkg::FSM_PRELOAD;         // weights first
                  else if (pl_done)
                     state <= conv_data_pkg::FSM_RELOAD_WEIGHTS;  // window waits
               end
               conv_data_pkg::FSM_PRELOAD: begin
                  if (pl_done) state <= conv_data_pkg::FSM_RUN;
               end
               conv_data_pkg::FSM_RELOAD_WEIGHTS: begin
                  if (weight_done_i) state <= conv_data_pkg::FSM_RUN;
               end
               conv_data_pkg::FSM_RUN: begin
                  if (ctrl.x_last_fire)
                     state <= more_feat ? conv_data_pkg::FSM_CHANGE_FEAT
                                        : conv_data_pkg::FSM_TERMINATE_PENDING;
               end
               conv_data_pkg::FSM_CHANGE_FEAT: begin
                  if (ctrl.y_last_fire) begin
                     state          <= conv_data_pkg::FSM_PLWL;
                     weight_start_o <= 1'b1;   // next weight set
                     n_og_o         <= n_og_o + 8'd1;
                  end
               end
               conv_data_pkg::FSM_TERMINATE_PENDING: begin
                  if (ctrl.y_last_fire) begin
                     state  <= conv_data_pkg::FSM_IDLE;
                     n_og_o <= n_og_o + 8'd1;
                  end
               end
               default: state <= conv_data_pkg::FSM_IDLE;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// ==== conv_weight_loader.sv ====
// weight loader that takes a 3x3 weight set from the weight stream on request
`timescale 1ns/10ps
`default_nettype none

module conv_weight_loader (
   input  logic                                               clk,
   input  logic                                               rst_n,
   input  logic                                               clear_i,
   input  logic                                               weight_start_i,
   input  logic                                               w_valid_i,
   input  conv_data_pkg::weight_t                             w_data_i,
   output logic                                               w_ready_o,
   output conv_data_pkg::weight_t [conv_data_pkg::N_TAPS-1:0] weights_o,
   output logic                                               weight_done_o
);

   logic       w_fire;
   logic [3:0] w_cnt;

   assign w_fire = w_valid_i & w_ready_o;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         w_ready_o     <= 1'b0;
         w_cnt         <= '0;
         weight_done_o <= 1'b0;
      end else begin
         weight_done_o <= 1'b0;
         if (clear_i) begin
            w_ready_o <= 1'b0;
            w_cnt     <= '0;
         end else if (weight_start_i) begin
            w_ready_o <= 1'b1;
            w_cnt     <= '0;
         end else if (w_fire) begin
            if (w_cnt == 4'(conv_data_pkg::N_TAPS - 1)) begin
               w_ready_o     <= 1'b0;
               weight_done_o <= 1'b1;
               w_cnt         <= '0;
            end else begin
               w_cnt <= w_cnt + 4'd1;
            end
         end
      end
   end

   // shift in from the top, w00 lands in slot 0
   always_ff @(posedge clk) begin
      if (w_fire) weights_o <= {w_data_i, weights_o[conv_data_pkg::N_TAPS-1:1]};
   end

endmodule

`default_nettype wire

// ==== conv_line_buffer.sv ====
// line buffer with two row memories and a 3x3 window register for valid-mode windows
`timescale 1ns/10ps
`default_nettype none

module conv_line_buffer #(
   parameter int MAX_LINE_LEN = 64
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  conv_cfg_pkg::line_len_t line_len_i,
   conv_stream_if.sink             x_in,
   conv_stream_if.source           win_out,
   conv_ctrl_if.datapath           ctrl
);

   localparam int AW = (MAX_LINE_LEN > 1) ? $clog2(MAX_LINE_LEN) : 1;

   conv_data_pkg::pixel_t                             line0 [MAX_LINE_LEN];  // row r-1
   conv_data_pkg::pixel_t                             line1 [MAX_LINE_LEN];  // row r-2
   conv_data_pkg::pixel_t [conv_data_pkg::N_TAPS-1:0] win;                   // raster order
   conv_data_pkg::pixel_t                             px;
   conv_cfg_pkg::line_len_t                           col;
   logic [1:0]                                        row;   // saturates at 2
   logic [AW-1:0]                                     addr;
   logic                                              win_valid;
   logic                                              win_last;
   logic                                              win_fire;
   logic                                              x_fire;

   assign px       = conv_data_pkg::pixel_t'(x_in.data);
   assign addr     = col[AW-1:0];
   assign x_fire   = x_in.valid & x_in.ready;
   assign win_fire = win_out.valid & win_out.ready;

   // window register takes a pixel only when empty or moving on
   assign x_in.ready       = ctrl.x_enable & (~win_valid | win_fire);
   assign ctrl.x_fire      = x_fire;
   assign ctrl.x_last_fire = x_fire & x_in.last;
   assign win_out.valid    = win_valid & ctrl.out_enable;
   assign win_out.data     = win;
   assign win_out.last     = win_last;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         col       <= '0;
         row       <= '0;
         win_valid <= 1'b0;
         win_last  <= 1'b0;
      end else if (ctrl.pipe_clear) begin
         col       <= '0;
         row       <= '0;
         win_valid <= 1'b0;
         win_last  <= 1'b0;
      end else if (x_fire) begin
         win_valid <= (row == 2'd2) && (col >= 16'd2);
         win_last  <= x_in.last;
         if (x_in.last) begin
            col <= '0;
            row <= '0;
         end else if (col == line_len_i - 16'd1) begin
            col <= '0;
            if (row != 2'd2) row <= row + 2'd1;
         end else begin
            col <= col + 16'd1;
         end
      end else if (win_fire) begin
         win_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (x_fire) begin
         line1[addr] <= line0[addr];
         line0[addr] <= px;
         for (int i = 0; i < 3; i++) begin
            win[3*i]     <= win[3*i + 1];
            win[3*i + 1] <= win[3*i + 2];
         end
         win[2] <= line1[addr];   // new right column
         win[5] <= line0[addr];
         win[8] <= px;
      end
   end

endmodule

`default_nettype wire

// ==== conv_mac_stage.sv ====
// MAC stage summing nine pixel-weight products into a held output register
`timescale 1ns/10ps
`default_nettype none

module conv_mac_stage (
   input  logic                                               clk,
   input  logic                                               rst_n,
   input  conv_data_pkg::weight_t [conv_data_pkg::N_TAPS-1:0] weights_i,
   conv_stream_if.sink                                        win_in,
   conv_stream_if.source                                      y_out,
   conv_ctrl_if.datapath                                      ctrl
);

   conv_data_pkg::acc_t sum;
   conv_data_pkg::acc_t y_data;
   logic                y_valid;
   logic                y_last;
   logic                win_fire;

   always_comb begin
      sum = '0;
      for (int k = 0; k < conv_data_pkg::N_TAPS; k++) begin
         sum = sum + conv_data_pkg::pixel_t'(win_in.data[conv_data_pkg::PIX_W*k +:
                                                          conv_data_pkg::PIX_W]) * weights_i[k];
      end
   end

   assign win_in.ready     = ~y_valid | y_out.ready;   // stall while result is held
   assign win_fire         = win_in.valid & win_in.ready;
   assign y_out.valid      = y_valid;
   assign y_out.data       = y_data;
   assign y_out.last       = y_last;
   assign ctrl.y_last_fire = y_valid & y_out.ready & y_last;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         y_valid <= 1'b0;
         y_last  <= 1'b0;
      end else if (ctrl.pipe_clear) begin
         y_valid <= 1'b0;
         y_last  <= 1'b0;
      end else if (win_fire) begin
         y_valid <= 1'b1;
         y_last  <= win_in.last;
      end else if (y_out.ready) begin
         y_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (win_fire) y_data <= sum;
   end

endmodule

`default_nettype wire

// ==== conv_top.sv ====
// convolution engine top level joining register block, FSM and stream data path
`timescale 1ns/10ps
`default_nettype none

module conv_top #(
   parameter int MAX_LINE_LEN = 64
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  conv_cfg_pkg::addr_t    s_axi_awaddr_i,
   input  logic                   s_axi_awvalid_i,
   output logic                   s_axi_awready_o,
   input  conv_cfg_pkg::data_t    s_axi_wdata_i,
   input  conv_cfg_pkg::strb_t    s_axi_wstrb_i,
   input  logic                   s_axi_wvalid_i,
   output logic                   s_axi_wready_o,
   output conv_cfg_pkg::resp_t    s_axi_bresp_o,
   output logic                   s_axi_bvalid_o,
   input  logic                   s_axi_bready_i,
   input  conv_cfg_pkg::addr_t    s_axi_araddr_i,
   input  logic                   s_axi_arvalid_i,
   output logic                   s_axi_arready_o,
   output conv_cfg_pkg::data_t    s_axi_rdata_o,
   output conv_cfg_pkg::resp_t    s_axi_rresp_o,
   output logic                   s_axi_rvalid_o,
   input  logic                   s_axi_rready_i,
   input  logic                   w_valid_i,
   input  conv_data_pkg::weight_t w_data_i,
   output logic                   w_ready_o,
   input  logic                   x_valid_i,
   input  conv_data_pkg::pixel_t  x_data_i,
   input  logic                   x_last_i,
   output logic                   x_ready_o,
   output logic                   y_valid_o,
   output conv_data_pkg::acc_t    y_data_o,
   output logic                   y_last_o,
   input  logic                   y_ready_i
);

   conv_data_pkg::fsm_state_t                         state;
   conv_cfg_pkg::nfeat_t                              n_og;
   conv_cfg_pkg::nfeat_t                              nfeat;
   conv_cfg_pkg::line_len_t                           line_len;
   logic                                              start;
   logic                                              clear;
   logic                                              weight_start;
   logic                                              weight_done;
   conv_data_pkg::weight_t [conv_data_pkg::N_TAPS-1:0] weights;

   conv_stream_if #(.DATA_W(conv_data_pkg::PIX_W))        x_if ();
   conv_stream_if #(.DATA_W(conv_data_pkg::WIN_W))        win_if ();
   conv_stream_if #(.DATA_W($bits(conv_data_pkg::acc_t))) y_if ();
   conv_ctrl_if                                           ctrl_if ();

   // pixel stream in, result stream out
   assign x_if.valid = x_valid_i;
   assign x_if.data  = x_data_i;
   assign x_if.last  = x_last_i;
   assign x_ready_o  = x_if.ready;
   assign y_valid_o  = y_if.valid;
   assign y_data_o   = y_if.data;
   assign y_last_o   = y_if.last;
   assign y_if.ready = y_ready_i;

   conv_regfile u_regfile (
      .*,
      .state_i    (state),
      .n_og_i     (n_og),
      .start_o    (start),
      .clear_o    (clear),
      .line_len_o (line_len),
      .nfeat_o    (nfeat)
   );

   conv_engine_fsm u_fsm (
      .clk            (clk),
      .rst_n          (rst_n),
      .start_i        (start),
      .clear_i        (clear),
      .line_len_i     (line_len),
      .nfeat_i        (nfeat),
      .weight_done_i  (weight_done),
      .weight_start_o (weight_start),
      .state_o        (state),
      .n_og_o         (n_og),
      .ctrl           (ctrl_if.fsm)
   );

   conv_weight_loader u_weights (
      .*,
      .clear_i        (clear),
      .weight_start_i (weight_start),
      .weights_o      (weights),
      .weight_done_o  (weight_done)
   );

   conv_line_buffer #(.MAX_LINE_LEN(MAX_LINE_LEN)) u_line_buffer (
      .clk        (clk),
      .rst_n      (rst_n),
      .line_len_i (line_len),
      .x_in       (x_if.sink),
      .win_out    (win_if.source),
      .ctrl       (ctrl_if.datapath)
   );

   conv_mac_stage u_mac (
      .clk       (clk),
      .rst_n     (rst_n),
      .weights_i (weights),
      .win_in    (win_if.sink),
      .y_out     (y_if.source),
      .ctrl      (ctrl_if.datapath)
   );

endmodule

`default_nettype wire

// ==== tb_conv_top.sv ====
// testbench for the convolution engine, driving AXI4-Lite and streams against a software model
`timescale 1ns/10ps
`default_nettype none

module tb_conv_top;

   localparam int WAIT_LIMIT = 2000;   // cycles allowed per wait

   logic                   clk = 1'b0;
   logic                   rst_n;
   conv_cfg_pkg::addr_t    s_axi_awaddr_i;
   logic                   s_axi_awvalid_i;
   logic                   s_axi_awready_o;
   conv_cfg_pkg::data_t    s_axi_wdata_i;
   conv_cfg_pkg::strb_t    s_axi_wstrb_i;
   logic                   s_axi_wvalid_i;
   logic                   s_axi_wready_o;
   conv_cfg_pkg::resp_t    s_axi_bresp_o;
   logic                   s_axi_bvalid_o;
   logic                   s_axi_bready_i;
   conv_cfg_pkg::addr_t    s_axi_araddr_i;
   logic                   s_axi_arvalid_i;
   logic                   s_axi_arready_o;
   conv_cfg_pkg::data_t    s_axi_rdata_o;
   conv_cfg_pkg::resp_t    s_axi_rresp_o;
   logic                   s_axi_rvalid_o;
   logic                   s_axi_rready_i;
   logic                   w_valid_i;
   conv_data_pkg::weight_t w_data_i;
   logic                   w_ready_o;
   logic                   x_valid_i;
   conv_data_pkg::pixel_t  x_data_i;
   logic                   x_last_i;
   logic                   x_ready_o;
   logic                   y_valid_o;
   conv_data_pkg::acc_t    y_data_o;
   logic                   y_last_o;
   logic                   y_ready_i;

   integer              seed = 51632;
   bit                  bp_on;            // random stalls on the result stream
   logic signed [7:0]   img [256];        // raster order image
   logic signed [7:0]   wset [9];         // w00 first
   int                  exp_q [$];

   always #50 clk = ~clk;

   conv_top #(.MAX_LINE_LEN(16)) DUT (.*);

   task automatic fail(input string msg);
      $display("%s", msg);
      $display("ERRORS FOUND");
      $fatal(1);
   endtask

   task automatic check(input bit ok, input string msg);
      assert (ok)
      else fail($sformatf("[ERROR] %0t: %s", $time, msg));
   endtask

   // one clock of a bounded wait
   task automatic step_cycle(inout int t, input string what);
      @(posedge clk);
      t++;
      if (t > WAIT_LIMIT) fail({"timeout waiting for ", what});
   endtask

   task automatic check_quiet();
      check(!y_valid_o && !x_ready_o && !w_ready_o, "stream handshake active in reset");
      check(!s_axi_awready_o && !s_axi_arready_o && !s_axi_bvalid_o && !s_axi_rvalid_o,
            "AXI handshake active in reset");
   endtask

   task automatic axi_write(input conv_cfg_pkg::addr_t addr, input conv_cfg_pkg::data_t data);
      int t;
      s_axi_awaddr_i  <= addr;
      s_axi_awvalid_i <= 1'b1;
      s_axi_wdata_i   <= data;
      s_axi_wstrb_i   <= 4'hF;
      s_axi_wvalid_i  <= 1'b1;
      t = 0;
      do step_cycle(t, "write address acceptance"); while (!s_axi_awready_o);
      check(s_axi_wready_o, "write data not taken with the address");
      s_axi_awvalid_i <= 1'b0;
      s_axi_wvalid_i  <= 1'b0;
      s_axi_bready_i  <= 1'b1;
      t = 0;
      do step_cycle(t, "write response"); while (!s_axi_bvalid_o);
      check(s_axi_bresp_o == conv_cfg_pkg::RESP_OKAY, "write response not OKAY");
      s_axi_bready_i <= 1'b0;
   endtask

   task automatic axi_read(input conv_cfg_pkg::addr_t addr, output conv_cfg_pkg::data_t data);
      int t;
      s_axi_araddr_i  <= addr;
      s_axi_arvalid_i <= 1'b1;
      t = 0;
      do step_cycle(t, "read address acceptance"); while (!s_axi_arready_o);
      s_axi_arvalid_i <= 1'b0;
      s_axi_rready_i  <= 1'b1;
      t = 0;
      do step_cycle(t, "read data"); while (!s_axi_rvalid_o);
      data = s_axi_rdata_o;
      check(s_axi_rresp_o == conv_cfg_pkg::RESP_OKAY, "read response not OKAY");
      s_axi_rready_i <= 1'b0;
   endtask

   task automatic expect_reg(input conv_cfg_pkg::addr_t addr, input conv_cfg_pkg::data_t value);
      conv_cfg_pkg::data_t got;
      axi_read(addr, got);
      check(got == value, $sformatf("register %h reads %h, expected %h", addr, got, value));
   endtask

   // random weights and image plus their valid-mode convolution
   task automatic make_feature(input int rows, input int cols);
      int acc;
      for (int k = 0; k < 9; k++) wset[k] = 8'($random(seed));
      for (int p = 0; p < rows * cols; p++) img[p] = 8'($random(seed));
      for (int r = 2; r < rows; r++) begin
         for (int c = 2; c < cols; c++) begin
            acc = 0;
            for (int i = 0; i < 3; i++) begin
               for (int j = 0; j < 3; j++) begin
                  acc += int'(wset[3*i + j]) * int'(img[(r - 2 + i) * cols + c - 2 + j]);
               end
            end
            exp_q.push_back(acc);
         end
      end
   endtask

   task automatic send_weights();
      int t;
      for (int k = 0; k < 9; k++) begin
         w_valid_i <= 1'b1;
         w_data_i  <= wset[k];
         t = 0;
         do step_cycle(t, "weight acceptance"); while (!w_ready_o);
      end
      w_valid_i <= 1'b0;
   endtask

   task automatic send_pixels(input int count, input bit mark_last);
      int t;
      for (int p = 0; p < count; p++) begin
         if (($random(seed) & 7) == 0) begin
            x_valid_i <= 1'b0;   // idle gap
            @(posedge clk);
         end
         x_valid_i <= 1'b1;
         x_data_i  <= img[p];
         x_last_i  <= mark_last && (p == count - 1);
         t = 0;
         do step_cycle(t, "pixel acceptance"); while (!x_ready_o);
      end
      x_valid_i <= 1'b0;
      x_last_i  <= 1'b0;
   endtask

   task automatic collect_results(input int n);
      int   got;
      int   idle;
      int   exp_v;
      bit   held;
      int   held_data;
      logic held_last;
      got  = 0;
      idle = 0;
      held = 1'b0;
      while (got < n) begin
         step_cycle(idle, "a result on the output stream");
         if (held)
            check(y_valid_o && y_data_o == held_data && y_last_o == held_last,
                  "held result changed under back-pressure");
         held = 1'b0;
         if (y_valid_o && y_ready_i) begin
            exp_v = exp_q.pop_front();
            check(y_data_o == exp_v,
                  $sformatf("result %0d is %0d, expected %0d", got, y_data_o, exp_v));
            check(y_last_o == (got == n - 1), $sformatf("wrong last flag on result %0d", got));
            got++;
            idle = 0;
         end else if (y_valid_o) begin
            held      = 1'b1;
            held_data = y_data_o;
            held_last = y_last_o;
         end
         if (bp_on) y_ready_i <= (($random(seed) & 3) != 0);
      end
      y_ready_i <= 1'b1;
   endtask

   task automatic run_job(input int nfeat, input int rows, input int cols);
      axi_write(conv_cfg_pkg::REG_LINE_LEN, cols);
      axi_write(conv_cfg_pkg::REG_NFEAT, nfeat);
      axi_write(conv_cfg_pkg::REG_CTRL, 32'h1);
      for (int f = 0; f < nfeat; f++) begin
         make_feature(rows, cols);
         fork
            send_weights();
            send_pixels(rows * cols, 1'b1);
            collect_results((rows - 2) * (cols - 2));
         join
         @(posedge clk);
         check(!y_valid_o, "result after the last one of a feature");
      end
      expect_reg(conv_cfg_pkg::REG_STATUS, nfeat << 8);   // idle with all features done
   endtask

   initial begin
      rst_n           <= 1'b0;
      s_axi_awaddr_i  <= '0;
      s_axi_awvalid_i <= 1'b0;
      s_axi_wdata_i   <= '0;
      s_axi_wstrb_i   <= '0;
      s_axi_wvalid_i  <= 1'b0;
      s_axi_bready_i  <= 1'b0;
      s_axi_araddr_i  <= '0;
      s_axi_arvalid_i <= 1'b0;
      s_axi_rready_i  <= 1'b0;
      w_valid_i       <= 1'b0;
      w_data_i        <= '0;
      x_valid_i       <= 1'b0;
      x_data_i        <= '0;
      x_last_i        <= 1'b0;
      y_ready_i       <= 1'b1;
      bp_on            = 1'b0;

      for (int i = 0; i < 16; i++) begin
         @(posedge clk);
         if (i > 0) check_quiet();
      end
      rst_n <= 1'b1;
      repeat (2) @(posedge clk);
      check_quiet();
      expect_reg(conv_cfg_pkg::REG_STATUS, 32'h0);

      // register access
      axi_write(conv_cfg_pkg::REG_LINE_LEN, 32'h0000_0abc);
      axi_write(conv_cfg_pkg::REG_NFEAT, 32'h0000_005a);
      axi_write(conv_cfg_pkg::REG_CTRL, 32'hffff_fffc);
      axi_write(conv_cfg_pkg::REG_STATUS, 32'hffff_ffff);
      axi_write(4'h6, 32'h1234_5678);
      expect_reg(conv_cfg_pkg::REG_LINE_LEN, 32'h0000_0abc);
      expect_reg(conv_cfg_pkg::REG_NFEAT, 32'h0000_005a);
      expect_reg(conv_cfg_pkg::REG_CTRL, 32'h0);
      expect_reg(conv_cfg_pkg::REG_STATUS, 32'h0);
      expect_reg(4'h6, 32'h0);
      expect_reg(4'h2, 32'h0);

      run_job(1, 5, 8);
      run_job(2, 4, 7);
      bp_on = 1'b1;
      run_job(1, 6, 12);
      bp_on = 1'b0;

      // clear in the middle of an image
      axi_write(conv_cfg_pkg::REG_LINE_LEN, 8);
      axi_write(conv_cfg_pkg::REG_NFEAT, 1);
      axi_write(conv_cfg_pkg::REG_CTRL, 32'h1);
      make_feature(5, 8);
      exp_q.delete();
      send_weights();
      send_pixels(23, 1'b0);
      expect_reg(conv_cfg_pkg::REG_STATUS, 32'h13);   // run and busy
      axi_write(conv_cfg_pkg::REG_CTRL, 32'h2);
      expect_reg(conv_cfg_pkg::REG_STATUS, 32'h0);
      run_job(1, 5, 8);

      $display("NO ERRORS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== conv_engine.f ====
conv_cfg_pkg.sv
conv_data_pkg.sv
conv_stream_if.sv
conv_regfile.sv
conv_engine_fsm.sv
conv_weight_loader.sv
conv_line_buffer.sv
conv_mac_stage.sv
conv_top.sv
tb_conv_top.sv

// ==== Bender.yml ====
package:
  name: conv_engine

sources:
  - files:
      - conv_cfg_pkg.sv
      - conv_data_pkg.sv
      - conv_stream_if.sv
      - conv_regfile.sv
      - conv_engine_fsm.sv
      - conv_weight_loader.sv
      - conv_line_buffer.sv
      - conv_mac_stage.sv
      - conv_top.sv
  - target: test
    files:
      - tb_conv_top.sv
